// File: source/spi_bus_pkg.sv
package spi_bus_pkg;

  localparam int NUM_CS = 3;

  typedef logic [2:0]        bus_addr_t;
  typedef logic [31:0]       bus_data_t;
  typedef logic [7:0]        spi_byte_t;
  typedef logic [NUM_CS-1:0] cs_t;         // active low

  localparam bus_addr_t ADDR_RX     = 3'd0; // write starts a read transfer
  localparam bus_addr_t ADDR_TX     = 3'd1; // write loads byte, starts a write
  localparam bus_addr_t ADDR_CS     = 3'd2;
  localparam bus_addr_t ADDR_MODE   = 3'd3; // wpol, wpha, rpol, rpha
  localparam bus_addr_t ADDR_MANUAL = 3'd4; // bit 1 sclk, bit 0 mosi
  localparam bus_addr_t ADDR_PINS   = 3'd5; // raw miso, read only

  // status word bits
  localparam int VALID_BIT = 8;
  localparam int DONE_BIT  = 8;
  localparam int BUSY_BIT  = 9;

  localparam int MODE_W = 4;

endpackage

// File: source/spi_link_pkg.sv
package spi_link_pkg;

  // bit 1 is the sclk idle level, bit 0 the phase
  typedef logic [1:0] spi_mode_t;

  localparam int POL_BIT = 1;
  localparam int PHA_BIT = 0;

  typedef enum logic [1:0] {
    IDLE,
    FIRST_HALF,
    SECOND_HALF,
    FINISH
  } seq_state_t;

  localparam int HALF_CYCLES     = 4;  // clk cycles per sclk half
  localparam int HALVES_PER_BYTE = 16;

  typedef logic [1:0] half_cnt_t;
  typedef logic [3:0] bit_cnt_t;

endpackage

// File: source/spi_ctrl_if.sv
`timescale 1ns/1ns

interface spi_ctrl_if;
  import spi_bus_pkg::*;
  import spi_link_pkg::*;

  logic      start_read;
  logic      start_write;
  spi_byte_t tx_byte;
  spi_mode_t read_mode;
  spi_mode_t write_mode;
  logic      busy;
  logic      done_read;
  logic      done_write;
  spi_byte_t rx_byte;   // from the shifter

  modport host (
    output start_read, start_write, tx_byte, read_mode, write_mode,
    input  busy, done_read, done_write, rx_byte
  );

  modport engine (
    input  start_read, start_write, read_mode, write_mode,
    output busy, done_read, done_write
  );

endinterface

// File: source/spi_regs.sv
`timescale 1ns/1ns

module spi_regs (
  input  logic                            clk,
  input  logic                            reset_n,
  input  spi_bus_pkg::bus_addr_t          bus_address,
  input  logic                            bus_read,
  input  logic                            bus_write,
  input  spi_bus_pkg::bus_data_t          bus_writedata,
  output spi_bus_pkg::bus_data_t          bus_readdata,
  output spi_bus_pkg::cs_t                cs_n,
  output logic                            manual_mosi,
  output logic                            manual_sclk,
  output logic                            manual_load,
  input  logic [spi_bus_pkg::NUM_CS-1:0]  miso,
  spi_ctrl_if.host                        ctrl
);
  import spi_bus_pkg::*;

  logic [MODE_W-1:0] mode_q;
  logic [1:0]        manual_q;
  spi_byte_t         tx_q;
  spi_byte_t         rx_q;
  logic              valid_q;
  logic              done_q;
  logic              idle;
  logic              wr_rx;
  logic              wr_tx;

  // a pending start counts as busy
  assign idle  = !ctrl.busy && !ctrl.start_read && !ctrl.start_write;
  assign wr_rx = bus_write && bus_address == ADDR_RX;
  assign wr_tx = bus_write && bus_address == ADDR_TX;

  assign manual_load = bus_write && bus_address == ADDR_MANUAL && idle;
  assign manual_mosi = bus_writedata[0];
  assign manual_sclk = bus_writedata[1];

  assign ctrl.tx_byte    = tx_q;
  assign ctrl.write_mode = mode_q[3:2];
  assign ctrl.read_mode  = mode_q[1:0];

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      cs_n             <= '1;
      mode_q           <= '0;
      manual_q         <= 2'b01;
      rx_q             <= '0;
      valid_q          <= 1'b0;
      done_q           <= 1'b0;
      ctrl.start_read  <= 1'b0;
      ctrl.start_write <= 1'b0;
    end else begin
      ctrl.start_read  <= wr_rx && idle;
      ctrl.start_write <= wr_tx && idle;
      if (bus_write && bus_address == ADDR_CS) cs_n <= bus_writedata[NUM_CS-1:0];
      if (bus_write && bus_address == ADDR_MODE) mode_q <= bus_writedata[MODE_W-1:0];
      if (manual_load) manual_q <= bus_writedata[1:0];
      // read clears, a new result wins
      if (bus_read && bus_address == ADDR_RX) valid_q <= 1'b0;
      if (bus_read && bus_address == ADDR_TX) done_q <= 1'b0;
      if (ctrl.done_read) begin
        valid_q <= 1'b1;
        rx_q    <= ctrl.rx_byte;
      end
      if (ctrl.done_write) done_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_tx && idle) tx_q <= bus_writedata[7:0];
  end

  always_comb begin
    bus_readdata = '0;
    case (bus_address)
      ADDR_RX: begin
        bus_readdata[7:0]       = rx_q;
        bus_readdata[VALID_BIT] = valid_q;
        bus_readdata[BUSY_BIT]  = ctrl.busy;
      end
      ADDR_TX: begin
        bus_readdata[DONE_BIT] = done_q;
        bus_readdata[BUSY_BIT] = ctrl.busy;
      end
      ADDR_CS:     bus_readdata[NUM_CS-1:0] = cs_n;
      ADDR_MODE:   bus_readdata[MODE_W-1:0] = mode_q;
      ADDR_MANUAL: bus_readdata[1:0]        = manual_q;
      ADDR_PINS:   bus_readdata[NUM_CS-1:0] = miso;
      default:     bus_readdata = '0;
    endcase
  end

endmodule

// File: source/spi_sequencer.sv
`timescale 1ns/1ns

module spi_sequencer (
  input  logic       clk,
  input  logic       reset_n,
  spi_ctrl_if.engine ctrl,
  input  logic       half_end,
  input  logic       byte_end,
  output logic       timer_run,
  output logic       sclk_level,
  output logic       drive_bit,
  output logic       sample_bit,
  output logic       reading
);
  import spi_link_pkg::*;

  seq_state_t state;
  seq_state_t state_next;
  seq_state_t prev_state;
  spi_mode_t  mode_q;
  logic       is_read;
  logic       half_first;
  logic       at_first;
  logic       at_second;
  logic       at_trail;

  always_comb begin
    state_next = state;
    case (state)
      IDLE:        if (ctrl.start_read || ctrl.start_write) state_next = FIRST_HALF;
      FIRST_HALF:  if (half_end) state_next = SECOND_HALF;
      SECOND_HALF: if (half_end) state_next = byte_end ? FINISH : FIRST_HALF;
      FINISH:      state_next = IDLE;
      default:     state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state      <= IDLE;
      prev_state <= IDLE;
      mode_q     <= '0;
      is_read    <= 1'b0;
    end else begin
      state      <= state_next;
      prev_state <= state;
      if (state == IDLE && (ctrl.start_read || ctrl.start_write)) begin
        is_read <= ctrl.start_read;
        mode_q  <= ctrl.start_read ? ctrl.read_mode : ctrl.write_mode;
      end
    end
  end

  // first cycle of each half
  assign half_first = state != prev_state;
  assign at_first   = half_first && state == FIRST_HALF;
  assign at_second  = half_first && state == SECOND_HALF;
  assign at_trail   = half_first && (state == FINISH ||
                      (state == FIRST_HALF && prev_state == SECOND_HALF));

  assign drive_bit  = !is_read && (mode_q[PHA_BIT] ? at_second : at_first);
  assign sample_bit = is_read && (mode_q[PHA_BIT] ? at_trail : at_second);

  // holds the last polarity while idle
  assign sclk_level = (state == SECOND_HALF) ? !mode_q[POL_BIT] : mode_q[POL_BIT];
  assign timer_run  = state == FIRST_HALF || state == SECOND_HALF;
  assign reading    = is_read && state != IDLE;

  assign ctrl.busy       = state != IDLE;
  assign ctrl.done_read  = state == FINISH && is_read;
  assign ctrl.done_write = state == FINISH && !is_read;

endmodule

// File: source/spi_bit_timer.sv
`timescale 1ns/1ns

module spi_bit_timer (
  input  logic clk,
  input  logic reset_n,
  input  logic run,
  output logic half_end,
  output logic byte_end
);
  import spi_link_pkg::*;

  half_cnt_t half_cnt;
  bit_cnt_t  bit_cnt;  // halves done in this byte

  assign half_end = run && half_cnt == half_cnt_t'(HALF_CYCLES - 1);
  assign byte_end = half_end && bit_cnt == bit_cnt_t'(HALVES_PER_BYTE - 1);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      half_cnt <= '0;
      bit_cnt  <= '0;
    end else if (!run) begin
      half_cnt <= '0;
      bit_cnt  <= '0;
    end else if (half_end) begin
      half_cnt <= '0;
      bit_cnt  <= bit_cnt + 1'b1;
    end else begin
      half_cnt <= half_cnt + 1'b1;
    end
  end

endmodule

// File: source/spi_shifter.sv
`timescale 1ns/1ns

module spi_shifter (
  input  logic                           clk,
  input  logic                           reset_n,
  input  logic                           load_tx,
  input  spi_bus_pkg::spi_byte_t         tx_byte,
  input  logic                           drive_bit,
  input  logic                           sample_bit,
  input  logic                           reading,
  input  logic                           sclk_level,
  input  logic                           manual_load,
  input  logic                           manual_mosi,
  input  logic                           manual_sclk,
  input  spi_bus_pkg::cs_t               cs_n,
  input  logic [spi_bus_pkg::NUM_CS-1:0] miso,
  output spi_bus_pkg::spi_byte_t         rx_byte,
  output logic                           mosi,
  output logic                           sclk
);
  import spi_bus_pkg::*;

  spi_byte_t tx_sr;
  spi_byte_t rx_sr;
  logic      miso_bit;
  logic      reading_q;
  logic      manual_hold;  // pins keep the manual levels
  logic      xfer_start;

  // lowest numbered select wins
  always_comb begin
    miso_bit = 1'b0;
    for (int i = NUM_CS - 1; i >= 0; i--) begin
      if (!cs_n[i]) miso_bit = miso[i];
    end
  end

  // last sample can land on the done cycle
  assign rx_byte    = sample_bit ? {rx_sr[6:0], miso_bit} : rx_sr;
  assign xfer_start = load_tx || (reading && !reading_q);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mosi        <= 1'b1;
      sclk        <= 1'b0;
      reading_q   <= 1'b0;
      manual_hold <= 1'b0;
    end else begin
      reading_q <= reading;
      if (manual_load) begin
        mosi        <= manual_mosi;
        sclk        <= manual_sclk;
        manual_hold <= 1'b1;
      end else begin
        if (xfer_start) manual_hold <= 1'b0;
        if (!manual_hold || xfer_start) sclk <= sclk_level;
        if (reading) mosi <= 1'b1;
        else if (drive_bit) mosi <= tx_sr[7];  // msb first
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load_tx) tx_sr <= tx_byte;
    else if (drive_bit) tx_sr <= {tx_sr[6:0], 1'b0};
    if (sample_bit) rx_sr <= {rx_sr[6:0], miso_bit};
  end

endmodule

// File: source/spi_master_top.sv
`timescale 1ns/1ns

module spi_master_top (
  input  logic                           clk,
  input  logic                           reset_n,
  input  spi_bus_pkg::bus_addr_t         bus_address,
  input  logic                           bus_read,
  input  logic                           bus_write,
  input  spi_bus_pkg::bus_data_t         bus_writedata,
  output spi_bus_pkg::bus_data_t         bus_readdata,
  input  logic [spi_bus_pkg::NUM_CS-1:0] miso,
  output logic                           mosi,
  output logic                           sclk,
  output spi_bus_pkg::cs_t               cs_n
);

  logic manual_mosi;
  logic manual_sclk;
  logic manual_load;
  logic half_end;
  logic byte_end;
  logic timer_run;
  logic sclk_level;
  logic drive_bit;
  logic sample_bit;
  logic reading;

  spi_ctrl_if ctrl ();

  spi_regs regs_i (
    .clk           (clk),
    .reset_n       (reset_n),
    .bus_address   (bus_address),
    .bus_read      (bus_read),
    .bus_write     (bus_write),
    .bus_writedata (bus_writedata),
    .bus_readdata  (bus_readdata),
    .cs_n          (cs_n),
    .manual_mosi   (manual_mosi),
    .manual_sclk   (manual_sclk),
    .manual_load   (manual_load),
    .miso          (miso),
    .ctrl          (ctrl.host)
  );

  spi_sequencer seq_i (
    .clk        (clk),
    .reset_n    (reset_n),
    .ctrl       (ctrl.engine),
    .half_end   (half_end),
    .byte_end   (byte_end),
    .timer_run  (timer_run),
    .sclk_level (sclk_level),
    .drive_bit  (drive_bit),
    .sample_bit (sample_bit),
    .reading    (reading)
  );

  spi_bit_timer timer_i (
    .clk      (clk),
    .reset_n  (reset_n),
    .run      (timer_run),
    .half_end (half_end),
    .byte_end (byte_end)
  );

  spi_shifter shifter_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .load_tx     (ctrl.start_write),
    .tx_byte     (ctrl.tx_byte),
    .drive_bit   (drive_bit),
    .sample_bit  (sample_bit),
    .reading     (reading),
    .sclk_level  (sclk_level),
    .manual_load (manual_load),
    .manual_mosi (manual_mosi),
    .manual_sclk (manual_sclk),
    .cs_n        (cs_n),
    .miso        (miso),
    .rx_byte     (ctrl.rx_byte),  // received byte onto the link
    .mosi        (mosi),
    .sclk        (sclk)
  );

endmodule

// File: test/spi_master_checker.sv
`timescale 1ns/1ns

module spi_master_checker (
  input logic             clk,
  input logic             reset_n,
  input logic             sclk,
  input spi_bus_pkg::cs_t cs_n,
  input logic             busy,
  input logic             manual_load
);
  import spi_link_pkg::*;

  localparam int MAX_BUSY = HALVES_PER_BYTE * HALF_CYCLES + 2;

  int         fail_count = 0;
  int         busy_cycles;
  logic       sclk_q;
  logic [3:0] same_cnt;  // cycles since the last sclk change

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      busy_cycles <= 0;
      sclk_q      <= 1'b0;
      same_cnt    <= '1;
    end else begin
      busy_cycles <= busy ? busy_cycles + 1 : 0;
      sclk_q      <= sclk;
      if (sclk != sclk_q) same_cnt <= '0;
      else if (same_cnt != '1) same_cnt <= same_cnt + 1'b1;  // saturates
    end
  end

  idle_sclk_a: assert property (@(posedge clk) disable iff (!reset_n)
      cs_n == '1 && !busy && $past(!busy) && !$past(manual_load) |-> $stable(sclk))
    else begin
      $error("sclk moved while idle with no chip select");
      fail_count++;
    end

  busy_limit_a: assert property (@(posedge clk) disable iff (!reset_n)
      busy |-> busy_cycles < MAX_BUSY)
    else begin
      $error("busy held longer than one byte transfer");
      fail_count++;
    end

  half_period_a: assert property (@(posedge clk) disable iff (!reset_n)
      busy && sclk != sclk_q |-> same_cnt >= HALF_CYCLES - 1)
    else begin
      $error("sclk changed inside a half period");
      fail_count++;
    end

endmodule

// File: test/spi_master_tb.sv
`timescale 1ns/1ns

module spi_master_tb;
  import spi_bus_pkg::*;
  import spi_link_pkg::*;

  localparam int CLK_PERIOD  = 20;
  localparam int NUM_READS   = 12;
  localparam int NUM_WRITES  = 12;
  localparam int NUM_XFERS   = NUM_READS + NUM_WRITES + 5;
  localparam int XFER_BUDGET = 100;  // cycles per transfer

  logic              clk;
  logic              reset_n;
  bus_addr_t         bus_address;
  logic              bus_read;
  logic              bus_write;
  bus_data_t         bus_writedata;
  bus_data_t         bus_readdata;
  logic [NUM_CS-1:0] miso;
  logic              mosi;
  logic              sclk;
  cs_t               cs_n;

  int checks = 0;
  int errors = 0;

  // one slave per chip select
  spi_byte_t slave_sent [NUM_CS];
  spi_byte_t slave_out [NUM_CS];
  spi_byte_t slave_in [NUM_CS];
  int        slave_bits [NUM_CS];
  logic      slave_started [NUM_CS];
  spi_mode_t slave_mode;
  logic      sclk_prev;

  spi_master_top dut_i (
    .clk           (clk),
    .reset_n       (reset_n),
    .bus_address   (bus_address),
    .bus_read      (bus_read),
    .bus_write     (bus_write),
    .bus_writedata (bus_writedata),
    .bus_readdata  (bus_readdata),
    .miso          (miso),
    .mosi          (mosi),
    .sclk          (sclk),
    .cs_n          (cs_n)
  );

  bind spi_master_top spi_master_checker checker_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .sclk        (sclk),
    .cs_n        (cs_n),
    .busy        (ctrl.busy),
    .manual_load (manual_load)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // leading edge leaves the idle level, trailing edge returns to it
  always @(negedge clk) begin
    logic lead;
    logic trail;
    lead      = sclk != sclk_prev && sclk != slave_mode[POL_BIT];
    trail     = sclk != sclk_prev && sclk == slave_mode[POL_BIT];
    sclk_prev = sclk;
    for (int i = 0; i < NUM_CS; i++) begin
      if (!cs_n[i]) begin
        if (lead) slave_started[i] = 1'b1;  // edges before this are start-up settling
        if (slave_mode[PHA_BIT] ? trail && slave_started[i] : lead) begin
          slave_in[i] = {slave_in[i][6:0], mosi};
          slave_bits[i]++;
        end
        if (slave_mode[PHA_BIT] ? lead : trail && slave_started[i]) begin
          miso[i]      = slave_out[i][7];
          slave_out[i] = slave_out[i] << 1;
        end
      end
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic bus_write_word(input bus_addr_t addr, input bus_data_t data);
    bus_address   = addr;
    bus_writedata = data;
    bus_write     = 1'b1;
    @(negedge clk);
    bus_write = 1'b0;
  endtask

  task automatic bus_read_word(input bus_addr_t addr, output bus_data_t data);
    bus_address = addr;
    bus_read    = 1'b1;
    @(posedge clk);
    data = bus_readdata;
    @(negedge clk);
    bus_read = 1'b0;
  endtask

  task automatic wait_flag(input bus_addr_t addr, input int flag_bit, output bus_data_t data);
    bus_read_word(addr, data);
    while (!data[flag_bit]) bus_read_word(addr, data);
  endtask

  task automatic arm_slaves(input spi_mode_t mode);
    slave_mode = mode;
    for (int i = 0; i < NUM_CS; i++) begin
      slave_sent[i]    = spi_byte_t'($urandom);
      slave_out[i]     = slave_sent[i];
      slave_in[i]      = '0;
      slave_bits[i]    = 0;
      slave_started[i] = 1'b0;
      if (!mode[PHA_BIT]) begin  // phase 0 shows the msb before the first edge
        miso[i]      = slave_out[i][7];
        slave_out[i] = slave_out[i] << 1;
      end
    end
  endtask

  // lowest selected slave drives the byte, none selected gives 0
  function automatic spi_byte_t expected_rx(input cs_t cs);
    for (int i = 0; i < NUM_CS; i++) begin
      if (!cs[i]) return slave_sent[i];
    end
    return '0;
  endfunction

  task automatic read_transfer(input cs_t cs, input spi_mode_t mode);
    bus_data_t data;
    bus_write_word(ADDR_CS, bus_data_t'(cs));
    check_value("cs_n pin", cs_n, bus_data_t'(cs));
    bus_write_word(ADDR_MODE, {28'd0, mode, mode});
    arm_slaves(mode);
    bus_write_word(ADDR_RX, 32'h0);
    wait_flag(ADDR_RX, VALID_BIT, data);
    check_value("rx_byte", data[7:0], expected_rx(cs));
    bus_read_word(ADDR_RX, data);
    check_value("valid after read", data[VALID_BIT], 1'b0);
  endtask

  task automatic write_transfer(input int sel, input spi_mode_t mode, input spi_byte_t value);
    bus_data_t data;
    bus_write_word(ADDR_CS, bus_data_t'(~cs_t'(1 << sel)));
    bus_write_word(ADDR_MODE, {28'd0, mode, mode});
    arm_slaves(mode);
    bus_write_word(ADDR_TX, bus_data_t'(value));
    wait_flag(ADDR_TX, DONE_BIT, data);
    check_value("slave bit count", slave_bits[sel], 8);
    check_value("slave mosi byte", slave_in[sel], value);
    bus_read_word(ADDR_TX, data);
    check_value("done after read", data[DONE_BIT], 1'b0);
  endtask

  initial begin
    bus_data_t  data;
    spi_byte_t  first;
    logic [1:0] level;
    void'($urandom(82428));
    reset_n       = 1'b0;
    bus_address   = '0;
    bus_read      = 1'b0;
    bus_write     = 1'b0;
    bus_writedata = '0;
    miso          = '0;
    slave_mode    = '0;
    sclk_prev     = 1'b0;
    repeat (5) @(negedge clk);
    reset_n = 1'b1;
    @(negedge clk);

    check_value("mosi", mosi, 1'b1);
    check_value("sclk", sclk, 1'b0);
    check_value("cs_n pin", cs_n, 32'h7);
    bus_read_word(ADDR_CS, data);
    check_value("cs_n", data, 32'h7);
    bus_read_word(ADDR_RX, data);
    check_value("rx status", data, 32'h0);
    bus_read_word(ADDR_TX, data);
    check_value("tx status", data, 32'h0);
    bus_read_word(ADDR_MODE, data);
    check_value("mode", data, 32'h0);

    for (int n = 0; n < NUM_READS; n++) begin
      read_transfer(~cs_t'(1 << ($urandom % NUM_CS)), spi_mode_t'($urandom));
    end
    for (int n = 0; n < NUM_WRITES; n++) begin
      write_transfer($urandom % NUM_CS, spi_mode_t'($urandom), spi_byte_t'($urandom));
    end

    // starts issued during a transfer are dropped
    bus_write_word(ADDR_CS, 32'h6);
    bus_write_word(ADDR_MODE, 32'h0);
    arm_slaves(2'b00);
    first = spi_byte_t'($urandom);
    bus_write_word(ADDR_TX, bus_data_t'(first));
    repeat (3) @(negedge clk);
    bus_read_word(ADDR_TX, data);
    check_value("busy", data[BUSY_BIT], 1'b1);
    bus_write_word(ADDR_TX, bus_data_t'(spi_byte_t'(~first)));
    bus_write_word(ADDR_RX, 32'h0);
    wait_flag(ADDR_TX, DONE_BIT, data);
    bus_read_word(ADDR_RX, data);
    check_value("busy and valid", data[BUSY_BIT:VALID_BIT], 2'b00);
    check_value("slave bit count", slave_bits[0], 8);
    check_value("slave mosi byte", slave_in[0], first);

    read_transfer(3'b000, 2'b00);
    read_transfer(3'b100, 2'b11);
    read_transfer(3'b001, 2'b01);
    read_transfer(3'b111, 2'b10);  // nothing selected

    bus_write_word(ADDR_CS, 32'h7);
    repeat (6) begin
      level = 2'($urandom);
      bus_write_word(ADDR_MANUAL, bus_data_t'(level));
      check_value("mosi", mosi, level[0]);
      check_value("sclk", sclk, level[1]);
      miso = 3'($urandom);
      bus_read_word(ADDR_PINS, data);
      check_value("miso pins", data, bus_data_t'(miso));
    end

    $display("%0d checks, %0d errors, %0d assertion failures",
             checks, errors, dut_i.checker_i.fail_count);
    if (errors == 0 && dut_i.checker_i.fail_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    #((NUM_XFERS * XFER_BUDGET + 500) * CLK_PERIOD);
    $display("timeout: the DUT did not finish its transfers in time");
    $display("%0d checks, %0d errors, %0d assertion failures",
             checks, errors, dut_i.checker_i.fail_count);
    $display("Test failed");
    $finish;
  end

endmodule

// File: sim.f
source/spi_bus_pkg.sv
source/spi_link_pkg.sv
source/spi_ctrl_if.sv
source/spi_regs.sv
source/spi_sequencer.sv
source/spi_bit_timer.sv
source/spi_shifter.sv
source/spi_master_top.sv
test/spi_master_checker.sv
test/spi_master_tb.sv

// File: Bender.yml
package:
  name: spi_master

sources:
  - source/spi_bus_pkg.sv
  - source/spi_link_pkg.sv
  - source/spi_ctrl_if.sv
  - source/spi_regs.sv
  - source/spi_sequencer.sv
  - source/spi_bit_timer.sv
  - source/spi_shifter.sv
  - source/spi_master_top.sv
  - target: test
    files:
      - test/spi_master_checker.sv
      - test/spi_master_tb.sv
